// ==== all.f ====
src/spu_pkg.sv
src/register_file.sv
src/byte_unit.sv
src/fixed_unit.sv
src/wb_merge.sv
src/spu_exec_top.sv
dv/spu_exec_tb.sv

// ==== dv/spu_exec_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module spu_exec_tb;

	localparam int drain_limit = 16;	// Cycles allowed to empty the pipeline

	logic                                clk;
	logic                                reset;
	logic [0:spu_pkg::op_width-1]        op;
	logic [spu_pkg::format_width-1:0]    format;
	logic [0:spu_pkg::addr_width-1]      ra_addr;
	logic [0:spu_pkg::addr_width-1]      rb_addr;
	logic [0:spu_pkg::addr_width-1]      rt_addr;
	logic [0:spu_pkg::imm_width-1]       imm;
	logic                                reg_write;
	logic                                branch_taken;
	wire  [0:spu_pkg::data_width-1]      rt_wb;
	wire  [0:spu_pkg::addr_width-1]      rt_addr_wb;
	wire                                 reg_write_wb;

	logic [0:spu_pkg::data_width-1] model_regs [spu_pkg::reg_count];	// Architectural state
	logic [0:spu_pkg::data_width-1] pend_result [$];	// One entry per issued cycle
	logic [0:spu_pkg::addr_width-1] pend_addr [$];
	logic                           pend_write [$];
	logic [0:spu_pkg::data_width-1] exp_result;	// Writeback expected at the next edge
	logic [0:spu_pkg::addr_width-1] exp_addr;
	logic                           exp_write;
	logic [31:0]                    lcg_state;

	spu_exec_top u_dut (
		.clk(clk), .reset(reset),
		.op(op), .format(format), .ra_addr(ra_addr), .rb_addr(rb_addr), .rt_addr(rt_addr),
		.imm(imm), .reg_write(reg_write), .branch_taken(branch_taken),
		.rt_wb(rt_wb), .rt_addr_wb(rt_addr_wb), .reg_write_wb(reg_write_wb)
	);

	always #4 clk = ~clk;

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Testbench failed");
		$fatal(1, "simulation stopped");
	endtask

	task automatic report_mismatch(input string what);
		abort_run($sformatf("[ERROR] %0t: %s", $time, what));
	endtask

	reset_quiet: assert property (@(posedge clk) reset |=> !reg_write_wb)
		else report_mismatch("reg_write_wb high during or right after reset");

	wb_write_check: assert property (@(posedge clk) disable iff (reset)
		reg_write_wb == exp_write)
		else report_mismatch($sformatf("reg_write_wb is %b, expected %b",
			$sampled(reg_write_wb), $sampled(exp_write)));

	wb_addr_check: assert property (@(posedge clk) disable iff (reset)
		rt_addr_wb == exp_addr)
		else report_mismatch($sformatf("rt_addr_wb is %0d, expected %0d",
			$sampled(rt_addr_wb), $sampled(exp_addr)));

	wb_data_check: assert property (@(posedge clk) disable iff (reset)
		rt_wb == exp_result)
		else report_mismatch($sformatf("rt_wb is %h, expected %h",
			$sampled(rt_wb), $sampled(exp_result)));

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state;
	endfunction

	function automatic int rand_below(input int n);
		return int'(lcg_next() >> 16) % n;
	endfunction

	function automatic logic [0:spu_pkg::imm_width-1] rand_imm();
		logic [31:0] r;
		r = lcg_next();
		return r[26:9];
	endfunction

	// Expected unit result from the instruction rules; known goes low when no unit owns it
	function automatic logic [0:spu_pkg::data_width-1] model_execute(
		input logic [0:spu_pkg::op_width-1]     code,
		input logic [spu_pkg::format_width-1:0] fmt,
		input logic [0:spu_pkg::data_width-1]   a,
		input logic [0:spu_pkg::data_width-1]   b,
		input logic [0:spu_pkg::imm_width-1]    imm_val,
		output logic                            known
	);
		logic [0:spu_pkg::data_width-1] r;
		int x;
		int y;
		r = '0;
		known = 1'b1;
		if (fmt == spu_pkg::fmt_ri10 && (code >> 3) == (spu_pkg::op_ai >> 3)) begin
			x = int'(imm_val & 18'h3ff);
			if (x >= 512)
				x = x - 1024;	// Sign of the 10-bit field
			for (int w = 0; w < 4; w++)
				r[32*w +: 32] = a[32*w +: 32] + x;
		end
		else if (fmt == spu_pkg::fmt_rr) begin
			case (code)
				spu_pkg::op_a: begin
					for (int w = 0; w < 4; w++)
						r[32*w +: 32] = a[32*w +: 32] + b[32*w +: 32];
				end
				spu_pkg::op_ah: begin
					for (int h = 0; h < 8; h++)
						r[16*h +: 16] = a[16*h +: 16] + b[16*h +: 16];
				end
				spu_pkg::op_and: r = a & b;
				spu_pkg::op_or:  r = a | b;
				spu_pkg::op_xor: r = a ^ b;
				spu_pkg::op_cntb: begin
					for (int i = 0; i < 16; i++)
						r[8*i +: 8] = 8'($countones(a[8*i +: 8]));
				end
				spu_pkg::op_avgb: begin
					for (int i = 0; i < 16; i++)
						r[8*i +: 8] = 8'((a[8*i +: 8] + b[8*i +: 8] + 1) / 2);
				end
				spu_pkg::op_absdb: begin
					for (int i = 0; i < 16; i++) begin
						x = $signed(a[8*i +: 8]) - $signed(b[8*i +: 8]);
						r[8*i +: 8] = 8'((x < 0) ? -x : x);
					end
				end
				spu_pkg::op_sumb: begin
					for (int w = 0; w < 4; w++) begin
						x = 0;
						y = 0;
						for (int j = 0; j < 4; j++) begin
							x = x + $signed(a[32*w + 8*j +: 8]);
							y = y + $signed(b[32*w + 8*j +: 8]);
						end
						r[32*w +: 16] = 16'(y);	// rb bytes go high
						r[32*w + 16 +: 16] = 16'(x);
					end
				end
				default: known = 1'b0;
			endcase
		end
		else begin
			known = 1'b0;
		end
		return r;
	endfunction

	function automatic int pending_write_count();
		int n;
		n = 0;
		foreach (pend_write[i])
			if (pend_write[i])
				n++;
		return n;
	endfunction

	// Drives an instruction for the next edge when called 1 ns after an edge
	task automatic issue(
		input logic [0:spu_pkg::op_width-1]     code,
		input logic [spu_pkg::format_width-1:0] fmt,
		input logic [0:spu_pkg::addr_width-1]   src_a,
		input logic [0:spu_pkg::addr_width-1]   src_b,
		input logic [0:spu_pkg::addr_width-1]   dst,
		input logic [0:spu_pkg::imm_width-1]    imm_val,
		input logic                             wr,
		input logic                             kill
	);
		logic [0:spu_pkg::data_width-1] value;
		logic                           known;
		logic                           writes;
		exp_result = pend_result.pop_front();	// Issued four edges back and commits next
		exp_addr   = pend_addr.pop_front();
		exp_write  = pend_write.pop_front();
		if (exp_write)
			model_regs[exp_addr] = exp_result;	// Visible through the bypass
		value  = model_execute(code, fmt, model_regs[src_a], model_regs[src_b], imm_val, known);
		writes = known && wr && !kill;
		pend_result.push_back(writes ? value : '0);
		pend_addr.push_back(writes ? dst : '0);
		pend_write.push_back(writes);
		op           = code;
		format       = fmt;
		ra_addr      = src_a;
		rb_addr      = src_b;
		rt_addr      = dst;
		imm          = imm_val;
		reg_write    = wr;
		branch_taken = kill;
		@(posedge clk);
		#1;
	endtask

	task automatic issue_rr(input logic [0:spu_pkg::op_width-1] code, input int a, b, t);
		issue(code, spu_pkg::fmt_rr, a, b, t, '0, 1'b1, 1'b0);
	endtask

	task automatic issue_ai(input int a, t, input logic [0:spu_pkg::imm_width-1] v);
		issue(spu_pkg::op_ai | 11'(rand_below(8)), spu_pkg::fmt_ri10, a, 0, t, v, 1'b1, 1'b0);
	endtask

	function automatic logic [0:spu_pkg::op_width-1] pick_fixed_op();
		case (rand_below(5))
			0: return spu_pkg::op_a;
			1: return spu_pkg::op_ah;
			2: return spu_pkg::op_and;
			3: return spu_pkg::op_or;
			default: return spu_pkg::op_xor;
		endcase
	endfunction

	function automatic logic [0:spu_pkg::op_width-1] pick_byte_op();
		case (rand_below(4))
			0: return spu_pkg::op_cntb;
			1: return spu_pkg::op_avgb;
			2: return spu_pkg::op_absdb;
			default: return spu_pkg::op_sumb;
		endcase
	endfunction

	task automatic random_mix(input int count);
		int kind;
		logic [0:spu_pkg::op_width-1] code;
		logic [spu_pkg::format_width-1:0] fmt;
		for (int i = 0; i < count; i++) begin
			kind = rand_below(8);
			fmt  = spu_pkg::fmt_rr;
			if (kind < 3) code = pick_fixed_op();
			else if (kind < 6) code = pick_byte_op();
			else if (kind == 6) begin
				code = spu_pkg::op_ai | 11'(rand_below(8));
				fmt  = spu_pkg::fmt_ri10;
			end
			else begin
				code = 11'(lcg_next() >> 5);	// Mostly unknown opcodes
				fmt  = 3'(rand_below(3));
			end
			issue(code, fmt, rand_below(32), rand_below(32), 1 + rand_below(31), rand_imm(),
				rand_below(8) != 0, rand_below(8) == 0);
		end
	endtask

	task automatic drain_pipeline();
		int cycles;
		cycles = 0;
		while ((pending_write_count() != 0 || reg_write_wb) && cycles < drain_limit) begin
			issue(spu_pkg::op_nop, spu_pkg::fmt_rr, 0, 0, 0, '0, 1'b0, 1'b0);
			cycles++;
		end
		if (pending_write_count() != 0 || reg_write_wb)
			abort_run($sformatf("Timeout: writebacks still pending after %0d cycles", cycles));
	endtask

	initial begin
		clk          = 1'b0;
		reset        = 1'b1;
		op           = spu_pkg::op_nop;
		format       = spu_pkg::fmt_rr;
		ra_addr      = '0;
		rb_addr      = '0;
		rt_addr      = '0;
		imm          = '0;
		reg_write    = 1'b0;
		branch_taken = 1'b0;
		exp_result   = '0;
		exp_addr     = '0;
		exp_write    = 1'b0;
		lcg_state    = 32'h340b;
		for (int i = 0; i < spu_pkg::reg_count; i++)
			model_regs[i] = '0;
		repeat (spu_pkg::exec_depth) begin
			pend_result.push_back('0);	// Bubbles left by reset
			pend_addr.push_back('0);
			pend_write.push_back(1'b0);
		end
		repeat (5) @(posedge clk);
		#1;
		reset = 1'b0;

		for (int r = 1; r < 32; r++)
			issue_ai(rand_below(r), r, rand_imm());	// Nonzero patterns
		for (int i = 0; i < 40; i++)
			issue_rr(pick_fixed_op(), rand_below(32), rand_below(32), 1 + rand_below(31));
		for (int i = 0; i < 40; i++)
			issue_rr(pick_byte_op(), rand_below(32), rand_below(32), 1 + rand_below(31));

		issue_ai(0, 40, 18'h3ff80);	// Every byte negative
		issue_ai(0, 41, 18'h0007f);
		repeat (4) issue(spu_pkg::op_nop, spu_pkg::fmt_rr, 0, 0, 0, '0, 1'b0, 1'b0);
		issue_rr(spu_pkg::op_absdb, 40, 41, 42);
		issue_rr(spu_pkg::op_absdb, 41, 40, 43);
		issue_rr(spu_pkg::op_sumb, 40, 40, 44);
		issue_rr(spu_pkg::op_sumb, 41, 40, 45);

		issue(spu_pkg::op_nop, spu_pkg::fmt_rr, 1, 2, 5, '0, 1'b1, 1'b0);
		issue(11'h7ff, spu_pkg::fmt_rr, 1, 2, 6, '0, 1'b1, 1'b0);
		issue(spu_pkg::op_a, spu_pkg::fmt_rr, 1, 2, 7, '0, 1'b1, 1'b1);	// Killed by branch
		issue(spu_pkg::op_cntb, spu_pkg::fmt_rr, 1, 2, 8, '0, 1'b0, 1'b0);
		issue(spu_pkg::op_a, 3'd2, 1, 2, 9, '0, 1'b1, 1'b0);

		for (int i = 0; i < 8; i++)
			issue_rr(pick_fixed_op(), rand_below(32), rand_below(32), 10 + i);
		for (int i = 0; i < 8; i++)
			issue_rr(pick_byte_op(), rand_below(32), rand_below(32), 18 + i);
		for (int i = 0; i < 16; i++) begin
			if (i % 2 == 0)
				issue_rr(pick_byte_op(), rand_below(32), rand_below(32), 1 + rand_below(31));
			else
				issue_rr(pick_fixed_op(), rand_below(32), rand_below(32), 1 + rand_below(31));
		end

		for (int r = 0; r < 6; r++) begin
			issue_ai(50, 50, rand_imm() | 18'h1);	// Producer
			for (int k = 1; k <= 5; k++)
				issue_rr(spu_pkg::op_a, 50, 0, 51 + k);
		end

		random_mix(200);
		for (int r = 0; r < 64; r++)
			issue_rr(spu_pkg::op_or, r, r, 127);	// Register readback
		drain_pipeline();
		$display("Testbench passed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== src/byte_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module byte_unit (
	input  wire                                 clk,
	input  wire                                 reset,
	input  wire  [0:spu_pkg::op_width-1]        op,
	input  wire  [spu_pkg::format_width-1:0]    format,
	input  wire  [0:spu_pkg::data_width-1]      ra,
	input  wire  [0:spu_pkg::data_width-1]      rb,
	input  wire  [0:spu_pkg::addr_width-1]      rt_addr,
	input  wire                                 reg_write,
	input  wire                                 branch_taken,
	output logic [0:spu_pkg::data_width-1]      result,
	output logic [0:spu_pkg::addr_width-1]      result_addr,
	output logic                                result_write
);

	// Delay line with entry 0 as stage 0
	logic [spu_pkg::exec_depth-1:0][0:spu_pkg::data_width-1] result_pipe;
	logic [spu_pkg::exec_depth-1:0][0:spu_pkg::addr_width-1] addr_pipe;
	logic [spu_pkg::exec_depth-1:0]                          write_pipe;

	logic [0:spu_pkg::data_width-1] stage0_result;
	logic                           stage0_valid;	// Owned and not killed

	logic [3:0]                           ones;		// Per-byte population count
	logic [spu_pkg::byte_width:0]         avg_sum;		// One extra bit for the carry
	logic signed [spu_pkg::byte_width-1:0] byte_a;
	logic signed [spu_pkg::byte_width-1:0] byte_b;
	logic signed [spu_pkg::half_width-1:0] sum_a;
	logic signed [spu_pkg::half_width-1:0] sum_b;

	always_comb begin
		stage0_result = '0;
		stage0_valid  = 1'b0;
		ones          = '0;
		avg_sum       = '0;
		byte_a        = '0;
		byte_b        = '0;
		sum_a         = '0;
		sum_b         = '0;
		if (!branch_taken && format == spu_pkg::fmt_rr) begin
			case (op)
				spu_pkg::op_cntb: begin
					stage0_valid = 1'b1;
					for (int i = 0; i < spu_pkg::byte_lanes; i++) begin
						ones = '0;
						for (int j = 0; j < spu_pkg::byte_width; j++) begin
							ones = ones + {3'b000, ra[spu_pkg::byte_width*i + j]};
						end
						stage0_result[spu_pkg::byte_width*i +: spu_pkg::byte_width] =
							{4'b0000, ones};
					end
				end
				spu_pkg::op_avgb: begin
					stage0_valid = 1'b1;
					for (int i = 0; i < spu_pkg::byte_lanes; i++) begin
						avg_sum = {1'b0, ra[spu_pkg::byte_width*i +: spu_pkg::byte_width]}
							+ {1'b0, rb[spu_pkg::byte_width*i +: spu_pkg::byte_width]}
							+ 9'd1;	// Round up
						stage0_result[spu_pkg::byte_width*i +: spu_pkg::byte_width] =
							avg_sum[spu_pkg::byte_width:1];
					end
				end
				spu_pkg::op_absdb: begin
					stage0_valid = 1'b1;
					for (int i = 0; i < spu_pkg::byte_lanes; i++) begin
						byte_a = ra[spu_pkg::byte_width*i +: spu_pkg::byte_width];
						byte_b = rb[spu_pkg::byte_width*i +: spu_pkg::byte_width];
						if (byte_a > byte_b) begin	// Signed compare
							stage0_result[spu_pkg::byte_width*i +: spu_pkg::byte_width] =
								byte_a - byte_b;
						end
						else begin
							stage0_result[spu_pkg::byte_width*i +: spu_pkg::byte_width] =
								byte_b - byte_a;
						end
					end
				end
				spu_pkg::op_sumb: begin
					stage0_valid = 1'b1;
					for (int w = 0; w < spu_pkg::word_lanes; w++) begin
						sum_a = '0;
						sum_b = '0;
						for (int j = 0; j < 4; j++) begin
							byte_a = ra[spu_pkg::word_width*w + spu_pkg::byte_width*j
								+: spu_pkg::byte_width];
							byte_b = rb[spu_pkg::word_width*w + spu_pkg::byte_width*j
								+: spu_pkg::byte_width];
							sum_a = sum_a + {{8{byte_a[7]}}, byte_a};	// Sign-extended
							sum_b = sum_b + {{8{byte_b[7]}}, byte_b};
						end
						// rb sum in the high halfword and ra sum in the low one
						stage0_result[spu_pkg::word_width*w +: spu_pkg::half_width] = sum_b;
						stage0_result[spu_pkg::word_width*w + spu_pkg::half_width
							+: spu_pkg::half_width] = sum_a;
					end
				end
				default: begin
					stage0_valid = 1'b0;	// Nop, unknown or fixed-unit opcode
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			result_pipe <= '0;
			addr_pipe   <= '0;
			write_pipe  <= '0;
		end
		else begin
			result_pipe[0] <= stage0_result;	// Zero for a bubble
			addr_pipe[0]   <= stage0_valid ? rt_addr : '0;
			write_pipe[0]  <= stage0_valid & reg_write;
			for (int s = 1; s < spu_pkg::exec_depth; s++) begin
				result_pipe[s] <= result_pipe[s-1];
				addr_pipe[s]   <= addr_pipe[s-1];
				write_pipe[s]  <= write_pipe[s-1];
			end
		end
	end

	assign result       = result_pipe[spu_pkg::exec_depth-1];
	assign result_addr  = addr_pipe[spu_pkg::exec_depth-1];
	assign result_write = write_pipe[spu_pkg::exec_depth-1];

	write_low_after_reset: assert property (@(posedge clk) reset |=> !result_write)
		else $error("byte_unit: result_write high after reset");

endmodule

`default_nettype wire

// ==== src/fixed_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module fixed_unit (
	input  wire                                 clk,
	input  wire                                 reset,
	input  wire  [0:spu_pkg::op_width-1]        op,
	input  wire  [spu_pkg::format_width-1:0]    format,
	input  wire  [0:spu_pkg::data_width-1]      ra,
	input  wire  [0:spu_pkg::data_width-1]      rb,
	input  wire  [0:spu_pkg::addr_width-1]      rt_addr,
	input  wire  [0:spu_pkg::imm_width-1]       imm,
	input  wire                                 reg_write,
	input  wire                                 branch_taken,
	output logic [0:spu_pkg::data_width-1]      result,
	output logic [0:spu_pkg::addr_width-1]      result_addr,
	output logic                                result_write
);

	logic [spu_pkg::exec_depth-1:0][0:spu_pkg::data_width-1] result_pipe;
	logic [spu_pkg::exec_depth-1:0][0:spu_pkg::addr_width-1] addr_pipe;
	logic [spu_pkg::exec_depth-1:0]                          write_pipe;

	logic [0:spu_pkg::data_width-1] stage0_result;
	logic                           stage0_valid;
	logic [0:spu_pkg::word_width-1] imm_ext;	// I10 field sign-extended to a word

	assign imm_ext = {{(spu_pkg::word_width - spu_pkg::ri10_width){imm[spu_pkg::imm_width -
		spu_pkg::ri10_width]}}, imm[spu_pkg::imm_width-spu_pkg::ri10_width:spu_pkg::imm_width-1]};

	always_comb begin
		stage0_result = '0;
		stage0_valid  = 1'b0;
		if (branch_taken) begin
			stage0_valid = 1'b0;	// Killed by a taken branch
		end
		else if (format == spu_pkg::fmt_rr) begin
			stage0_valid = 1'b1;
			case (op)
				spu_pkg::op_a: begin
					for (int w = 0; w < spu_pkg::word_lanes; w++) begin
						stage0_result[spu_pkg::word_width*w +: spu_pkg::word_width] =
							ra[spu_pkg::word_width*w +: spu_pkg::word_width]
							+ rb[spu_pkg::word_width*w +: spu_pkg::word_width];
					end
				end
				spu_pkg::op_ah: begin
					for (int h = 0; h < spu_pkg::half_lanes; h++) begin
						stage0_result[spu_pkg::half_width*h +: spu_pkg::half_width] =
							ra[spu_pkg::half_width*h +: spu_pkg::half_width]
							+ rb[spu_pkg::half_width*h +: spu_pkg::half_width];
					end
				end
				spu_pkg::op_and: stage0_result = ra & rb;
				spu_pkg::op_or:  stage0_result = ra | rb;
				spu_pkg::op_xor: stage0_result = ra ^ rb;
				default: begin
					stage0_valid = 1'b0;	// Nop or not ours
				end
			endcase
		end
		else if (format == spu_pkg::fmt_ri10 &&
			op[0:spu_pkg::ri10_op_width-1] == spu_pkg::op_ai[0:spu_pkg::ri10_op_width-1]) begin
			stage0_valid = 1'b1;
			for (int w = 0; w < spu_pkg::word_lanes; w++) begin
				stage0_result[spu_pkg::word_width*w +: spu_pkg::word_width] =
					ra[spu_pkg::word_width*w +: spu_pkg::word_width] + imm_ext;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			result_pipe <= '0;
			addr_pipe   <= '0;
			write_pipe  <= '0;
		end
		else begin
			result_pipe[0] <= stage0_result;
			addr_pipe[0]   <= stage0_valid ? rt_addr : '0;
			write_pipe[0]  <= stage0_valid & reg_write;
			for (int s = 1; s < spu_pkg::exec_depth; s++) begin
				result_pipe[s] <= result_pipe[s-1];	// Shift toward writeback
				addr_pipe[s]   <= addr_pipe[s-1];
				write_pipe[s]  <= write_pipe[s-1];
			end
		end
	end

	assign result       = result_pipe[spu_pkg::exec_depth-1];
	assign result_addr  = addr_pipe[spu_pkg::exec_depth-1];
	assign result_write = write_pipe[spu_pkg::exec_depth-1];

	write_low_after_reset: assert property (@(posedge clk) reset |=> !result_write)
		else $error("fixed_unit: result_write high after reset");

endmodule

`default_nettype wire

// ==== src/register_file.sv ====
`timescale 1ns/1ps
`default_nettype none

module register_file (
	input  wire                               clk,
	input  wire                               reset,
	input  wire  [0:spu_pkg::addr_width-1]    ra_addr,
	input  wire  [0:spu_pkg::addr_width-1]    rb_addr,
	input  wire  [0:spu_pkg::addr_width-1]    wr_addr,
	input  wire  [0:spu_pkg::data_width-1]    wr_data,
	input  wire                               wr_en,
	output logic [0:spu_pkg::data_width-1]    ra,
	output logic [0:spu_pkg::data_width-1]    rb
);

	logic [0:spu_pkg::data_width-1] regs [spu_pkg::reg_count];	// Architectural registers

	logic ra_bypass;
	logic rb_bypass;

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < spu_pkg::reg_count; i++) begin
				regs[i] <= '0;
			end
		end
		else if (wr_en) begin
			regs[wr_addr] <= wr_data;	// Commit from writeback
		end
	end

	// A read of the register being committed this cycle sees the new value
	assign ra_bypass = wr_en && (wr_addr == ra_addr);
	assign rb_bypass = wr_en && (wr_addr == rb_addr);

	always_comb begin
		if (ra_bypass) begin
			ra = wr_data;
		end
		else begin
			ra = regs[ra_addr];
		end
	end

	always_comb begin
		if (rb_bypass) begin
			rb = wr_data;
		end
		else begin
			rb = regs[rb_addr];
		end
	end

	wr_addr_known: assert property (
		@(posedge clk) disable iff (reset)
		wr_en |-> !$isunknown(wr_addr)
	)
	else $error("register_file: write enabled with unknown address");

endmodule

`default_nettype wire

// ==== src/spu_exec_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module spu_exec_top (
	input  wire                                 clk,
	input  wire                                 reset,
	input  wire  [0:spu_pkg::op_width-1]        op,
	input  wire  [spu_pkg::format_width-1:0]    format,
	input  wire  [0:spu_pkg::addr_width-1]      ra_addr,
	input  wire  [0:spu_pkg::addr_width-1]      rb_addr,
	input  wire  [0:spu_pkg::addr_width-1]      rt_addr,
	input  wire  [0:spu_pkg::imm_width-1]       imm,
	input  wire                                 reg_write,
	input  wire                                 branch_taken,
	output logic [0:spu_pkg::data_width-1]      rt_wb,
	output logic [0:spu_pkg::addr_width-1]      rt_addr_wb,
	output logic                                reg_write_wb
);

	wire [0:spu_pkg::data_width-1] ra;	// Operands after bypass
	wire [0:spu_pkg::data_width-1] rb;

	wire [0:spu_pkg::data_width-1] byte_result;
	wire [0:spu_pkg::addr_width-1] byte_addr;
	wire                           byte_write;
	wire [0:spu_pkg::data_width-1] fixed_result;
	wire [0:spu_pkg::addr_width-1] fixed_addr;
	wire                           fixed_write;

	register_file u_register_file (
		.clk(clk), .reset(reset),
		.ra_addr(ra_addr), .rb_addr(rb_addr),
		.wr_addr(rt_addr_wb), .wr_data(rt_wb), .wr_en(reg_write_wb),	// Writeback port
		.ra(ra), .rb(rb)
	);

	byte_unit u_byte_unit (
		.clk(clk), .reset(reset),
		.op(op), .format(format), .ra(ra), .rb(rb),
		.rt_addr(rt_addr), .reg_write(reg_write), .branch_taken(branch_taken),
		.result(byte_result), .result_addr(byte_addr), .result_write(byte_write)
	);

	fixed_unit u_fixed_unit (
		.clk(clk), .reset(reset),
		.op(op), .format(format), .ra(ra), .rb(rb),
		.rt_addr(rt_addr), .imm(imm), .reg_write(reg_write), .branch_taken(branch_taken),
		.result(fixed_result), .result_addr(fixed_addr), .result_write(fixed_write)
	);

	wb_merge u_wb_merge (
		.byte_result(byte_result), .byte_addr(byte_addr), .byte_write(byte_write),
		.fixed_result(fixed_result), .fixed_addr(fixed_addr), .fixed_write(fixed_write),
		.rt_wb(rt_wb), .rt_addr_wb(rt_addr_wb), .reg_write_wb(reg_write_wb)
	);

endmodule

`default_nettype wire

// ==== src/spu_pkg.sv ====
`default_nettype none

package spu_pkg;

	localparam int data_width    = 128;	// Register width
	localparam int addr_width    = 7;	// Register address width
	localparam int reg_count     = 128;
	localparam int op_width      = 11;
	localparam int format_width  = 3;
	localparam int imm_width     = 18;
	localparam int exec_depth    = 4;	// Stages in each execution unit

	localparam int byte_width    = 8;
	localparam int half_width    = 16;
	localparam int word_width    = 32;
	localparam int byte_lanes    = data_width / byte_width;
	localparam int half_lanes    = data_width / half_width;
	localparam int word_lanes    = data_width / word_width;
	localparam int ri10_width    = 10;	// Immediate field of the RI10 format
	localparam int ri10_op_width = 8;	// Opcode bits that identify an RI10 instruction

	// Instruction formats
	localparam logic [format_width-1:0] fmt_rr   = 3'd0;
	localparam logic [format_width-1:0] fmt_ri10 = 3'd1;

	localparam logic [0:op_width-1] op_nop   = 11'b00000000000;

	// Byte unit, RR format
	localparam logic [0:op_width-1] op_cntb  = 11'b01010110100;
	localparam logic [0:op_width-1] op_avgb  = 11'b00011010011;
	localparam logic [0:op_width-1] op_absdb = 11'b00001010011;
	localparam logic [0:op_width-1] op_sumb  = 11'b01001010011;

	// Fixed-point unit, RR format
	localparam logic [0:op_width-1] op_a     = 11'b00011000000;
	localparam logic [0:op_width-1] op_ah    = 11'b00011001000;
	localparam logic [0:op_width-1] op_and   = 11'b00011000001;
	localparam logic [0:op_width-1] op_or    = 11'b00001000001;
	localparam logic [0:op_width-1] op_xor   = 11'b01001000001;

	// Fixed-point unit, RI10 format, only the top 8 bits are significant
	localparam logic [0:op_width-1] op_ai    = 11'b00011100000;

endpackage

`default_nettype wire

// ==== src/wb_merge.sv ====
`timescale 1ns/1ps
`default_nettype none

module wb_merge (
	input  wire  [0:spu_pkg::data_width-1]    byte_result,
	input  wire  [0:spu_pkg::addr_width-1]    byte_addr,
	input  wire                               byte_write,
	input  wire  [0:spu_pkg::data_width-1]    fixed_result,
	input  wire  [0:spu_pkg::addr_width-1]    fixed_addr,
	input  wire                               fixed_write,
	output logic [0:spu_pkg::data_width-1]    rt_wb,
	output logic [0:spu_pkg::addr_width-1]    rt_addr_wb,
	output logic                              reg_write_wb
);

	always_comb begin
		if (byte_write) begin
			rt_wb        = byte_result;
			rt_addr_wb   = byte_addr;
			reg_write_wb = 1'b1;
		end
		else if (fixed_write) begin
			rt_wb        = fixed_result;
			rt_addr_wb   = fixed_addr;
			reg_write_wb = 1'b1;
		end
		else begin
			rt_wb        = '0;	// No write this cycle
			rt_addr_wb   = '0;
			reg_write_wb = 1'b0;
		end
	end

	// Opcode sets of the two units are disjoint and both have the same latency
	always_comb begin
		single_writer: assert final (!(byte_write === 1'b1 && fixed_write === 1'b1))
			else $error("wb_merge: both units write back in the same cycle");
	end

endmodule

`default_nettype wire
